// File: vlog.f
+incdir+dv
hdl/wasm_isa_pkg.sv
hdl/stack_cpu_pkg.sv
hdl/leb128_decoder.sv
hdl/fetch_decode.sv
hdl/int_alu.sv
hdl/execute_unit.sv
hdl/operand_stack.sv
hdl/wasm_cpu.sv
dv/tb_wasm_cpu.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0 -Wno-fatal
TOP       = tb_wasm_cpu
FILELIST  = vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

// File: dv/wasm_ref_model.svh
`ifndef WASM_REF_MODEL_SVH
`define WASM_REF_MODEL_SVH

// Signed LEB128 starting at addr, returns value and byte count
task automatic leb_decode(input int addr, output value_t val, output int n);
  logic [7:0] b;
  int shift;
  val = '0;
  n = 10;
  shift = 70;
  b = 8'h00;
  for (int i = 0; i < 10; i++) begin
    b = byte_at(addr + i);
    val = val | (value_t'(b[6:0]) << (7 * i));
    if (!b[7]) begin
      n = i + 1;
      shift = 7 * n;
      break;
    end
  end
  if (shift < 64 && b[6]) val = val | ({64{1'b1}} << shift);
endtask

// Interprets the program from address 0 until something stops it
task automatic model_run(output trap_t t, output value_t v, output value_type_t ty,
                         output bit emp);
  value_t vs [8];
  value_type_t tys [8];
  value_type_t opt;
  value_t imm;
  value_t a;
  value_t b;
  value_t r;
  logic [7:0] op;
  int d;
  int pc;
  int n;
  int steps;
  t = TRAP_NONE;
  d = 0;
  pc = 0;
  steps = 0;
  while (t == TRAP_NONE && steps < 4000) begin
    steps++;
    n = 1;
    if (pc >= err_limit) begin
      t = TRAP_MEM_ERROR;
    end else begin
      op = byte_at(pc);
      opt = (op == 8'h42 || (op >= 8'h50 && op <= 8'h52) || op >= 8'h7c) ? I64 : I32;
      case (op)
        8'h01: ;
        8'h00: t = TRAP_UNREACHABLE;
        8'h0b: t = TRAP_ENDED;
        8'h41, 8'h42: begin
          leb_decode(pc + 1, imm, n);
          n = n + 1;
          if (d == 8) begin
            t = TRAP_STACK_OVERFLOW;
          end else begin
            vs[d] = (op == 8'h41) ? {32'b0, imm[31:0]} : imm;
            tys[d] = opt;
            d++;
          end
        end
        8'h1a: begin
          if (d < 1) t = TRAP_STACK_EMPTY;
          else d--;
        end
        8'h45, 8'h50: begin
          if (d < 1) t = TRAP_STACK_EMPTY;
          else if (tys[d-1] != opt) t = TRAP_TYPE_MISMATCH;
          else begin
            vs[d-1] = (opt == I64) ? value_t'(vs[d-1] == 0) : value_t'(vs[d-1][31:0] == 0);
            tys[d-1] = I32;
          end
        end
        8'h46, 8'h47, 8'h6a, 8'h6b, 8'h51, 8'h52, 8'h7c, 8'h7d: begin
          if (d < 2) t = TRAP_STACK_EMPTY;
          else if (tys[d-1] != opt || tys[d-2] != opt) t = TRAP_TYPE_MISMATCH;
          else begin
            a = vs[d-2];
            b = vs[d-1];
            if (opt == I32) begin
              a = {32'b0, a[31:0]};
              b = {32'b0, b[31:0]};
            end
            case (op)
              8'h46, 8'h51: r = value_t'(a == b);
              8'h47, 8'h52: r = value_t'(a != b);
              8'h6a, 8'h7c: r = a + b;
              default:      r = a - b;
            endcase
            if (opt == I32) r = {32'b0, r[31:0]};
            d--;
            vs[d-1] = r;
            tys[d-1] = (op == 8'h6a || op == 8'h6b || op >= 8'h7c) ? opt : I32;
          end
        end
        8'h1b: begin
          if (d < 3) t = TRAP_STACK_EMPTY;
          else if (tys[d-1] != I32 || tys[d-2] != tys[d-3]) t = TRAP_TYPE_MISMATCH;
          else begin
            r = (vs[d-1] != 0) ? vs[d-3] : vs[d-2];
            d = d - 2;
            vs[d-1] = r;
          end
        end
        default: t = TRAP_UNKNOWN_OPCODE;
      endcase
    end
    pc = pc + n;
  end
  emp = (d == 0);
  v = emp ? 64'b0 : vs[d-1];
  ty = emp ? I32 : tys[d-1];
endtask

`endif

// File: dv/tb_wasm_cpu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_wasm_cpu;
  import wasm_isa_pkg::*;
  import stack_cpu_pkg::*;

  logic          clk;
  logic          reset;
  logic [9:0]    start_pc;
  logic [9:0]    mem_addr;
  fetch_window_t mem_data;
  logic          mem_error;
  value_t        result;
  value_type_t   result_type;
  logic          result_empty;
  trap_t         trap;

  logic [7:0]  mem [1024];
  int          err_limit;
  int          plen;
  value_type_t ts [8];
  int          td;
  int          seed;
  int          trap_errs;
  int          value_errs;
  int          type_errs;
  int          empty_errs;
  int          timeouts;

  wasm_cpu DUT (
    .clk(clk), .reset(reset), .start_pc(start_pc), .mem_addr(mem_addr),
    .mem_data(mem_data), .mem_error(mem_error), .result(result),
    .result_type(result_type), .result_empty(result_empty), .trap(trap)
  );

  always #5 clk = ~clk;

  function automatic logic [7:0] byte_at(input int addr);
    return (addr >= 0 && addr < 1024) ? mem[addr] : 8'h00;
  endfunction

  // Byte memory read through an eleven-byte window
  always_comb begin
    for (int i = 0; i < 11; i++) mem_data[8*i +: 8] = byte_at(int'(mem_addr) + i);
    mem_error = (int'(mem_addr) >= err_limit);
  end

  `include "wasm_ref_model.svh"

  task automatic check_trap(input trap_t got, input trap_t exp);
    if (got !== exp) begin
      $display("[ERROR] trap got %h expected %h", got, exp);
      trap_errs++;
    end
  endtask

  task automatic check_value(input value_t got, input value_t exp);
    if (got !== exp) begin
      $display("[ERROR] result got %h expected %h", got, exp);
      value_errs++;
    end
  endtask

  task automatic check_type(input value_type_t got, input value_type_t exp);
    if (got !== exp) begin
      $display("[ERROR] result_type got %h expected %h", got, exp);
      type_errs++;
    end
  endtask

  task automatic check_empty(input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] result_empty got %h expected %h", got, exp);
      empty_errs++;
    end
  endtask

  task automatic clear_program();
    for (int i = 0; i < 1024; i++) mem[i] = 8'h00;
    plen = 0;
    td = 0;
    err_limit = 1024;
  endtask

  task automatic put_byte(input logic [7:0] b);
    mem[plen] = b;
    plen++;
  endtask

  // Constant with an n-byte LEB128 immediate padded with continuation bytes
  task automatic put_const(input bit is64, input value_t v, input int n);
    logic signed [63:0] sv;
    sv = v;
    put_byte(is64 ? 8'h42 : 8'h41);
    for (int i = 0; i < n; i++) begin
      put_byte({(i < n - 1), 7'(sv >>> (7 * i))});
    end
    if (td < 8) begin
      ts[td] = is64 ? I64 : I32;
      td++;
    end
  endtask

  task automatic put_random_const();
    bit is64;
    value_t v;
    is64 = $random(seed);
    v = {$random(seed), $random(seed)};
    if ($random(seed) & 1) v = v >>> ({$random(seed)} % 64);
    put_const(is64, v, is64 ? 1 + {$random(seed)} % 10 : 1 + {$random(seed)} % 5);
  endtask

  // Well-typed random instructions that track operand types
  task automatic gen_valid(input int count);
    int r;
    bit done;
    for (int k = 0; k < count; k++) begin
      r = {$random(seed)} % 8;
      done = 1'b0;
      if (r == 2) begin
        put_byte(8'h01);
        done = 1'b1;
      end else if (r == 3 && td >= 1) begin
        put_byte(8'h1a);
        td--;
        done = 1'b1;
      end else if (r == 4 && td >= 1) begin
        put_byte(ts[td-1] == I64 ? 8'h50 : 8'h45);
        ts[td-1] = I32;
        done = 1'b1;
      end else if ((r == 5 || r == 6) && td >= 2 && ts[td-1] == ts[td-2]) begin
        r = {$random(seed)} % 4;
        put_byte(ts[td-1] == I64 ? (r < 2 ? 8'h51 + r : 8'h7a + r) :
                                  (r < 2 ? 8'h46 + r : 8'h68 + r));
        td--;
        if (r < 2) ts[td-1] = I32;
        done = 1'b1;
      end else if (r == 7 && td >= 3 && ts[td-1] == I32 && ts[td-2] == ts[td-3]) begin
        put_byte(8'h1b);
        td = td - 2;
        done = 1'b1;
      end
      if (!done) begin
        if (td < 8) put_random_const();
        else begin
          put_byte(8'h1a);
          td--;
        end
      end
    end
  endtask

  task automatic run_program();
    int cycles;
    trap_t mt;
    value_t mv;
    value_type_t mty;
    bit me;
    @(negedge clk);
    reset = 1'b1;
    start_pc = '0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    cycles = 0;
    while (trap == TRAP_NONE && cycles < 3000) begin
      @(negedge clk);
      cycles++;
    end
    if (trap == TRAP_NONE) begin
      $display("Timeout: the CPU raised no trap within %0d cycles", cycles);
      timeouts++;
    end else begin
      model_run(mt, mv, mty, me);
      check_trap(trap, mt);
      check_empty(result_empty, me);
      if (result_empty === me && !me) begin
        check_value(result, mv);
        check_type(result_type, mty);
      end
    end
  endtask

  initial begin
    logic [7:0] bad [5];
    value_t v;
    bad = '{8'h02, 8'h10, 8'h20, 8'h99, 8'hff};
    clk = 1'b0;
    reset = 1'b1;
    start_pc = '0;
    seed = 32'hc096_2afb;
    trap_errs = 0;
    value_errs = 0;
    type_errs = 0;
    empty_errs = 0;
    timeouts = 0;
    clear_program();

    // Well-typed programs
    for (int t = 0; t < 40; t++) begin
      clear_program();
      gen_valid(5 + {$random(seed)} % 30);
      put_byte(8'h0b);
      run_program();
    end

    // Every immediate length with both signs and both widths
    for (int n = 1; n <= 10; n++) begin
      for (int s = 0; s < 4; s++) begin
        clear_program();
        v = {$random(seed), $random(seed)};
        // Top bit of the last encoded group carries the sign
        v[(7 * n - 1 < 63) ? 7 * n - 1 : 63] = s[0];
        put_const(s[1], v, n);
        put_byte(8'h0b);
        run_program();
      end
    end

    // Mixed operand types and bad select conditions
    for (int t = 0; t < 10; t++) begin
      clear_program();
      gen_valid({$random(seed)} % 6);
      put_const(1'b0, 64'd7, 1);
      put_const(1'b1, 64'd7, 1);
      if (t % 2) put_const(1'b1, 64'd1, 1);
      put_byte(t % 2 ? 8'h1b : (t % 4 ? 8'h7c : 8'h6a));
      put_byte(8'h0b);
      run_program();
    end

    // Underflow and overflow
    for (int t = 0; t < 10; t++) begin
      clear_program();
      gen_valid({$random(seed)} % 8);
      for (int k = 0; k < 9; k++) begin
        if (t % 2) put_random_const();
        else put_byte(8'h1a);
      end
      put_byte(8'h0b);
      run_program();
    end

    // Unreachable and undefined opcode bytes
    for (int t = 0; t < 10; t++) begin
      clear_program();
      gen_valid(1 + {$random(seed)} % 10);
      put_byte(t % 2 ? 8'h00 : bad[{$random(seed)} % 5]);
      gen_valid(3);
      put_byte(8'h0b);
      run_program();
    end

    // Without end the fetch runs into the memory error limit
    for (int t = 0; t < 5; t++) begin
      clear_program();
      gen_valid(1 + {$random(seed)} % 12);
      err_limit = plen;
      run_program();
    end

    $display("Errors: trap %0d value %0d type %0d empty %0d timeouts %0d",
             trap_errs, value_errs, type_errs, empty_errs, timeouts);
    if (trap_errs + value_errs + type_errs + empty_errs + timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/wasm_cpu.sv
`timescale 1ns/1ns
`default_nettype none

module wasm_cpu #(
  parameter int MEM_AW   = 10,
  parameter int STACK_AW = 3
) (
  input  wire                               clk,
  input  wire                               reset,
  input  wire [MEM_AW-1:0]                  start_pc,
  output wire [MEM_AW-1:0]                  mem_addr,
  input  wire stack_cpu_pkg::fetch_window_t mem_data,
  input  wire                               mem_error,
  output wire stack_cpu_pkg::value_t        result,
  output wire wasm_isa_pkg::value_type_t    result_type,
  output wire                               result_empty,
  output wire stack_cpu_pkg::trap_t         trap
);
  import wasm_isa_pkg::*;
  import stack_cpu_pkg::*;

  // Fetch to execute
  logic              insn_stb;
  opcode_t           opcode;
  value_t            imm;
  logic              fetch_error;
  logic              halted;

  // Execute to stack
  stack_op_t         stack_op;
  value_t            push_value;
  value_type_t       push_type;

  // Stack outputs below the top; the top itself drives result
  value_t            nos;
  value_t            third;
  value_type_t       nos_type;
  value_type_t       third_type;
  logic [STACK_AW:0] depth;
  logic              full;
  value_t            alu_value;

  fetch_decode #(.MEM_AW(MEM_AW)) u_fetch (
    .clk(clk), .reset(reset), .start_pc(start_pc), .halted(halted),
    .mem_addr(mem_addr), .mem_data(mem_data), .mem_error(mem_error),
    .insn_stb(insn_stb), .opcode(opcode), .imm(imm), .fetch_error(fetch_error)
  );

  execute_unit #(.STACK_AW(STACK_AW)) u_exec (
    .clk(clk), .reset(reset), .insn_stb(insn_stb), .opcode(opcode), .imm(imm),
    .fetch_error(fetch_error), .tos_type(result_type), .nos_type(nos_type),
    .third_type(third_type), .tos(result), .nos(nos), .third(third), .depth(depth),
    .full(full), .alu_value(alu_value), .stack_op(stack_op), .push_value(push_value),
    .push_type(push_type), .trap(trap), .halted(halted)
  );

  int_alu u_alu (.opcode(opcode), .tos(result), .nos(nos), .alu_value(alu_value));

  operand_stack #(.STACK_AW(STACK_AW)) u_stack (
    .clk(clk), .reset(reset), .stack_op(stack_op), .push_value(push_value),
    .push_type(push_type), .tos(result), .nos(nos), .third(third),
    .tos_type(result_type), .nos_type(nos_type), .third_type(third_type),
    .depth(depth), .empty(result_empty), .full(full)
  );

endmodule

`default_nettype wire

// File: hdl/operand_stack.sv
`timescale 1ns/1ns
`default_nettype none

module operand_stack #(
  parameter int STACK_AW = 3
) (
  input  wire                            clk,
  input  wire                            reset,
  input  wire stack_cpu_pkg::stack_op_t  stack_op,
  input  wire stack_cpu_pkg::value_t     push_value,
  input  wire wasm_isa_pkg::value_type_t push_type,
  output stack_cpu_pkg::value_t          tos,
  output stack_cpu_pkg::value_t          nos,
  output stack_cpu_pkg::value_t          third,
  output wasm_isa_pkg::value_type_t      tos_type,
  output wasm_isa_pkg::value_type_t      nos_type,
  output wasm_isa_pkg::value_type_t      third_type,
  output logic [STACK_AW:0]              depth,
  output logic                           empty,
  output logic                           full
);
  import wasm_isa_pkg::*;
  import stack_cpu_pkg::*;

  localparam int ENTRIES = 2 ** STACK_AW;

  value_t              values [ENTRIES];
  value_type_t         types  [ENTRIES];
  logic [STACK_AW:0]   ptr;
  logic [STACK_AW-1:0] tos_idx;
  logic [STACK_AW-1:0] nos_idx;
  logic [STACK_AW-1:0] third_idx;
  logic [STACK_AW-1:0] wr_idx;
  logic                wr_en;

  // ptr counts entries, so the top sits at ptr - 1
  assign tos_idx   = STACK_AW'(ptr - 1);
  assign nos_idx   = STACK_AW'(ptr - 2);
  assign third_idx = STACK_AW'(ptr - 3);

  // Slot that receives the pushed value
  always_comb begin
    wr_en = 1'b1;
    case (stack_op)
      STK_PUSH:      wr_idx = ptr[STACK_AW-1:0];
      STK_REPLACE:   wr_idx = tos_idx;
      STK_POP2_PUSH: wr_idx = nos_idx;
      STK_POP3_PUSH: wr_idx = third_idx;
      default: begin
        wr_en  = 1'b0;
        wr_idx = tos_idx;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else begin
      case (stack_op)
        STK_PUSH:      ptr <= ptr + 1'b1;
        STK_POP:       ptr <= ptr - 1'b1;
        STK_POP2_PUSH: ptr <= ptr - 1'b1;
        STK_POP3_PUSH: ptr <= ptr - 2'd2;
        default:       ptr <= ptr;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      values[wr_idx] <= push_value;
      types[wr_idx]  <= push_type;
    end
  end

  // Slots past the depth read as zero
  assign tos        = (ptr >= 1) ? values[tos_idx] : 64'b0;
  assign nos        = (ptr >= 2) ? values[nos_idx] : 64'b0;
  assign third      = (ptr >= 3) ? values[third_idx] : 64'b0;
  assign tos_type   = (ptr >= 1) ? types[tos_idx] : I32;
  assign nos_type   = (ptr >= 2) ? types[nos_idx] : I32;
  assign third_type = (ptr >= 3) ? types[third_idx] : I32;

  assign depth = ptr;
  assign empty = (ptr == '0);
  assign full  = (ptr == ENTRIES);

endmodule

`default_nettype wire

// File: hdl/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module execute_unit #(
  parameter int STACK_AW = 3
) (
  input  wire                            clk,
  input  wire                            reset,
  input  wire                            insn_stb,
  input  wire wasm_isa_pkg::opcode_t     opcode,
  input  wire stack_cpu_pkg::value_t     imm,
  input  wire                            fetch_error,
  input  wire wasm_isa_pkg::value_type_t tos_type,
  input  wire wasm_isa_pkg::value_type_t nos_type,
  input  wire wasm_isa_pkg::value_type_t third_type,
  input  wire stack_cpu_pkg::value_t     tos,
  input  wire stack_cpu_pkg::value_t     nos,
  input  wire stack_cpu_pkg::value_t     third,
  input  wire [STACK_AW:0]               depth,
  input  wire                            full,
  input  wire stack_cpu_pkg::value_t     alu_value,
  output stack_cpu_pkg::stack_op_t       stack_op,
  output stack_cpu_pkg::value_t          push_value,
  output wasm_isa_pkg::value_type_t      push_type,
  output stack_cpu_pkg::trap_t           trap,
  output logic                           halted
);
  import wasm_isa_pkg::*;
  import stack_cpu_pkg::*;

  trap_t       trap_next;
  value_type_t operand_type;
  logic        is_arith;

  // Operand type implied by the opcode
  assign operand_type = (opcode inside {OP_I64_CONST, OP_I64_EQZ, OP_I64_EQ, OP_I64_NE,
                                        OP_I64_ADD, OP_I64_SUB}) ? I64 : I32;
  assign is_arith     = opcode inside {OP_I32_ADD, OP_I32_SUB, OP_I64_ADD, OP_I64_SUB};

  always_comb begin
    stack_op   = STK_NONE;
    push_value = alu_value;
    push_type  = I32;
    trap_next  = TRAP_NONE;
    if (insn_stb && !halted) begin
      if (fetch_error) begin
        trap_next = TRAP_MEM_ERROR;
      end else begin
        case (opcode)
          OP_NOP: begin
          end
          OP_UNREACHABLE: trap_next = TRAP_UNREACHABLE;
          OP_END:         trap_next = TRAP_ENDED;
          OP_I32_CONST, OP_I64_CONST: begin
            if (full) begin
              trap_next = TRAP_STACK_OVERFLOW;
            end else begin
              stack_op   = STK_PUSH;
              push_value = imm;
              push_type  = operand_type;
            end
          end
          OP_DROP: begin
            if (depth < 1) trap_next = TRAP_STACK_EMPTY;
            else stack_op = STK_POP;
          end
          OP_I32_EQZ, OP_I64_EQZ: begin
            if (depth < 1) trap_next = TRAP_STACK_EMPTY;
            else if (tos_type != operand_type) trap_next = TRAP_TYPE_MISMATCH;
            else stack_op = STK_REPLACE;
          end
          OP_I32_EQ, OP_I32_NE, OP_I32_ADD, OP_I32_SUB,
          OP_I64_EQ, OP_I64_NE, OP_I64_ADD, OP_I64_SUB: begin
            if (depth < 2) begin
              trap_next = TRAP_STACK_EMPTY;
            end else if (tos_type != operand_type || nos_type != operand_type) begin
              trap_next = TRAP_TYPE_MISMATCH;
            end else begin
              stack_op = STK_POP2_PUSH;
              // Comparisons always give an i32
              if (is_arith) push_type = operand_type;
            end
          end
          OP_SELECT: begin
            if (depth < 3) begin
              trap_next = TRAP_STACK_EMPTY;
            end else if (tos_type != I32 || nos_type != third_type) begin
              trap_next = TRAP_TYPE_MISMATCH;
            end else begin
              stack_op   = STK_POP3_PUSH;
              // Nonzero condition keeps the deeper operand
              push_value = (tos != 64'b0) ? third : nos;
              push_type  = third_type;
            end
          end
          default: trap_next = TRAP_UNKNOWN_OPCODE;
        endcase
      end
    end
  end

  // First trap sticks until reset
  always_ff @(posedge clk) begin
    if (reset) begin
      trap <= TRAP_NONE;
    end else if (trap_next != TRAP_NONE) begin
      trap <= trap_next;
    end
  end

  assign halted = (trap != TRAP_NONE);

endmodule

`default_nettype wire

// File: hdl/int_alu.sv
`timescale 1ns/1ns
`default_nettype none

module int_alu (
  input  wire wasm_isa_pkg::opcode_t opcode,
  input  wire stack_cpu_pkg::value_t tos,
  input  wire stack_cpu_pkg::value_t nos,
  output stack_cpu_pkg::value_t      alu_value
);
  import wasm_isa_pkg::*;
  import stack_cpu_pkg::*;

  // nos is the left operand, tos the right one
  word_t lhs32;
  word_t rhs32;

  assign lhs32 = nos[31:0];
  assign rhs32 = tos[31:0];

  always_comb begin
    case (opcode)
      // i32 forms, result zero-extended
      OP_I32_EQZ: alu_value = {63'b0, rhs32 == 32'b0};
      OP_I32_EQ:  alu_value = {63'b0, lhs32 == rhs32};
      OP_I32_NE:  alu_value = {63'b0, lhs32 != rhs32};
      OP_I32_ADD: alu_value = {32'b0, lhs32 + rhs32};
      OP_I32_SUB: alu_value = {32'b0, lhs32 - rhs32};

      // i64 forms
      OP_I64_EQZ: alu_value = {63'b0, tos == 64'b0};
      OP_I64_EQ:  alu_value = {63'b0, nos == tos};
      OP_I64_NE:  alu_value = {63'b0, nos != tos};
      OP_I64_ADD: alu_value = nos + tos;
      OP_I64_SUB: alu_value = nos - tos;

      default:    alu_value = 64'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/fetch_decode.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_decode #(
  parameter int MEM_AW = 10
) (
  input  wire                               clk,
  input  wire                               reset,
  input  wire [MEM_AW-1:0]                  start_pc,
  input  wire                               halted,
  output logic [MEM_AW-1:0]                 mem_addr,
  input  wire stack_cpu_pkg::fetch_window_t mem_data,
  input  wire                               mem_error,
  output logic                              insn_stb,
  output wasm_isa_pkg::opcode_t             opcode,
  output stack_cpu_pkg::value_t             imm,
  output logic                              fetch_error
);
  import wasm_isa_pkg::*;
  import stack_cpu_pkg::*;

  typedef enum logic {
    FETCH_ADDR,
    FETCH_CAPTURE
  } fetch_state_t;

  fetch_state_t      state;
  logic [MEM_AW-1:0] pc;
  opcode_t           win_opcode;
  logic              has_imm;
  value_t            leb_value;
  leb_len_t          leb_len;
  leb_len_t          advance;

  // Immediate bytes follow the opcode byte
  leb128_decoder u_leb (
    .bytes (mem_data[8*WINDOW_BYTES-1:8]),
    .value (leb_value),
    .len   (leb_len)
  );

  assign win_opcode = opcode_t'(mem_data[7:0]);
  assign has_imm    = (win_opcode == OP_I32_CONST) || (win_opcode == OP_I64_CONST);
  assign advance    = has_imm ? leb_len + 4'd1 : 4'd1;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= FETCH_ADDR;
      pc       <= start_pc;
      mem_addr <= '0;
      insn_stb <= 1'b0;
    end else begin
      insn_stb <= 1'b0;
      case (state)
        FETCH_ADDR: begin
          if (!halted) begin
            mem_addr <= pc;
            state    <= FETCH_CAPTURE;
          end
        end
        FETCH_CAPTURE: begin
          state <= FETCH_ADDR;
          // A trap raised by the previous item cancels this one
          if (!halted) begin
            pc       <= pc + MEM_AW'(advance);
            insn_stb <= 1'b1;
          end
        end
        default: state <= FETCH_ADDR;
      endcase
    end
  end

  // Instruction payload, qualified by insn_stb
  always_ff @(posedge clk) begin
    if (state == FETCH_CAPTURE) begin
      opcode      <= win_opcode;
      imm         <= (win_opcode == OP_I32_CONST) ? {32'b0, leb_value[31:0]} : leb_value;
      fetch_error <= mem_error;
    end
  end

endmodule

`default_nettype wire

// File: hdl/leb128_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module leb128_decoder (
  input  wire [8*wasm_isa_pkg::LEB_MAX_BYTES-1:0] bytes,
  output stack_cpu_pkg::value_t                   value,
  output stack_cpu_pkg::leb_len_t                 len
);
  import wasm_isa_pkg::*;
  import stack_cpu_pkg::*;

  localparam int ACC_BITS = LEB_GROUP_BITS * LEB_MAX_BYTES;

  logic [ACC_BITS-1:0] acc;
  logic                sign;
  logic                done;
  leb_len_t            count;

  always_comb begin
    acc   = '0;
    sign  = 1'b0;
    done  = 1'b0;
    // No terminator found means the full ten bytes
    count = leb_len_t'(LEB_MAX_BYTES);
    for (int i = 0; i < LEB_MAX_BYTES; i++) begin
      if (!done) begin
        acc[LEB_GROUP_BITS*i +: LEB_GROUP_BITS] = bytes[8*i +: LEB_GROUP_BITS];
        sign = bytes[8*i + LEB_GROUP_BITS - 1];
        // Continuation bit clear ends the number
        if (!bytes[8*i + LEB_GROUP_BITS]) begin
          done  = 1'b1;
          count = leb_len_t'(i + 1);
        end
      end
    end
    // Sign bit fills everything above the last group
    for (int j = 0; j < ACC_BITS; j++) begin
      if (j >= LEB_GROUP_BITS * int'(count)) begin
        acc[j] = sign;
      end
    end
  end

  assign value = acc[63:0];
  assign len   = count;

endmodule

`default_nettype wire

// File: hdl/stack_cpu_pkg.sv
`default_nettype none

package stack_cpu_pkg;

  // Stack payload, an i32 sits zero-extended in the low half
  typedef logic [63:0] value_t;
  typedef logic [31:0] word_t;

  // Immediate length in bytes
  typedef logic [3:0] leb_len_t;

  // Opcode byte in the low byte, then the ten immediate bytes
  localparam int WINDOW_BYTES = 11;
  typedef logic [8*WINDOW_BYTES-1:0] fetch_window_t;

  typedef enum logic [2:0] {
    STK_NONE,
    STK_PUSH,
    STK_POP,
    STK_REPLACE,
    STK_POP2_PUSH,
    STK_POP3_PUSH
  } stack_op_t;

  typedef enum logic [3:0] {
    TRAP_NONE,
    TRAP_ENDED,
    TRAP_UNREACHABLE,
    TRAP_UNKNOWN_OPCODE,
    TRAP_TYPE_MISMATCH,
    TRAP_STACK_EMPTY,
    TRAP_STACK_OVERFLOW,
    TRAP_MEM_ERROR
  } trap_t;

endpackage

`default_nettype wire

// File: hdl/wasm_isa_pkg.sv
`default_nettype none

package wasm_isa_pkg;

  // Opcode bytes of the supported instructions
  typedef enum logic [7:0] {
    OP_UNREACHABLE = 8'h00,
    OP_NOP         = 8'h01,
    OP_END         = 8'h0b,
    OP_DROP        = 8'h1a,
    OP_SELECT      = 8'h1b,
    OP_I32_CONST   = 8'h41,
    OP_I64_CONST   = 8'h42,
    OP_I32_EQZ     = 8'h45,
    OP_I32_EQ      = 8'h46,
    OP_I32_NE      = 8'h47,
    OP_I64_EQZ     = 8'h50,
    OP_I64_EQ      = 8'h51,
    OP_I64_NE      = 8'h52,
    OP_I32_ADD     = 8'h6a,
    OP_I32_SUB     = 8'h6b,
    OP_I64_ADD     = 8'h7c,
    OP_I64_SUB     = 8'h7d
  } opcode_t;

  // Type code is 0x7f minus the type byte of the binary format
  // Float codes kept reserved, never produced here
  typedef enum logic [1:0] {
    I32 = 2'd0,
    I64 = 2'd1,
    F32 = 2'd2,
    F64 = 2'd3
  } value_type_t;

  // Longest signed LEB128 immediate (varint64)
  localparam int LEB_MAX_BYTES = 10;

  // Payload bits per LEB128 byte
  localparam int LEB_GROUP_BITS = 7;

endpackage

`default_nettype wire
